//--- include/dn_defines.svh
`ifndef DN_DEFINES_SVH
`define DN_DEFINES_SVH

// Incoming message width, sign in the msb
`define DN_MSG_W 4

// Folded y0 magnitude, message width less the sign
`define DN_MAG_W 3

// Page address inside one bank
`define DN_PAGE_W 6

// Table banks, selected by the lsb of the folded y1
`define DN_BANKS 2

// Rows per bank including the offset bit
`define DN_LUT_DEPTH 128

// Cycles from input sampling to t_c
`define DN_LATENCY 3

`endif

//--- logic/dn_pkg.sv
`include "dn_defines.svh"

package dn_pkg;

	//////////////////////////////
	// Message types
	//////////////////////////////

	// Raw channel message as it arrives at a read port
	typedef logic [`DN_MSG_W-1:0] msg_t;

	// y0 with the sign folded out
	typedef logic [`DN_MAG_W-1:0] mag_t;

	//////////////////////////////
	// Table addressing
	//////////////////////////////

	// Page inside one bank, {mag, y1_fold[3:1]}
	typedef logic [`DN_PAGE_W-1:0] page_t;

	// Full row index, {offset, page}
	// The offset bit selects the upper or lower half of a bank
	typedef logic [`DN_PAGE_W:0] row_t;

endpackage

//--- logic/dn_msg_if.sv
`timescale 1ns/1ps

interface dn_msg_if;
	import dn_pkg::*;

	// Folded y0 magnitude
	mag_t mag;

	// y1 after conditional inversion
	msg_t y1_fold;

	// Fold flag, needed again at the hard decision
	logic flag;

	// Page offset captured with this message
	logic offset;

	// Fold stage drives everything
	modport src (
		output mag,
		output y1_fold,
		output flag,
		output offset
	);

	// Table and decision stages only read
	modport dst (
		input mag,
		input y1_fold,
		input flag,
		input offset
	);

endinterface

//--- logic/dn_msg_fold.sv
`timescale 1ns/1ps
`include "dn_defines.svh"

module dn_msg_fold (
	input  logic         read_clk,
	input  logic         arst_n,
	input  logic         transpose_en,
	input  dn_pkg::msg_t y0,
	input  dn_pkg::msg_t y1,
	input  logic         read_addr_offset,
	dn_msg_if.src        msg
);
	import dn_pkg::*;

	logic sign;
	mag_t mag_nxt;
	msg_t y1_nxt;
	logic flag_nxt;

	//////////////////////////////
	// Symmetry fold
	//////////////////////////////

	assign sign = y0[`DN_MSG_W-1];

	// Negative y0 maps onto the positive half by inverting the low bits
	assign mag_nxt = y0[`DN_MAG_W-1:0] ^ {`DN_MAG_W{sign}};

	// Transpose and sign both flip the decision
	assign flag_nxt = transpose_en ^ sign;

	// y1 follows the flag so the pair stays on the folded half
	assign y1_nxt = flag_nxt ? ~y1 : y1;

	//////////////////////////////
	// Stage 0 registers
	//////////////////////////////

	always_ff @(posedge read_clk or negedge arst_n) begin
		if (!arst_n) begin
			msg.mag     <= '0;
			msg.y1_fold <= '0;
			msg.flag    <= 1'b0;
			msg.offset  <= 1'b0;
		end else begin
			msg.mag     <= mag_nxt;
			msg.y1_fold <= y1_nxt;
			msg.flag    <= flag_nxt;
			msg.offset  <= read_addr_offset;
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// The flag travels two more stages and lands on t_c,
	// an X here would corrupt the decision three cycles later
	flag_known_a: assert property (
		@(posedge read_clk) disable iff (!arst_n)
		!$isunknown(msg.flag)
	) else $error("dn_msg_fold: fold flag is unknown");

endmodule

//--- logic/dn_lut_bank.sv
`timescale 1ns/1ps
`include "dn_defines.svh"

module dn_lut_bank (
	input  logic          read_clk,
	input  logic          arst_n,
	dn_msg_if.dst         msg_a,
	dn_msg_if.dst         msg_b,
	input  logic          we,
	input  logic          lut_in_bank0,
	input  logic          lut_in_bank1,
	input  dn_pkg::page_t page_write_addr,
	input  logic          write_addr_offset,
	output logic          lut_a,
	output logic          lut_b
);
	import dn_pkg::*;

	// One bit per row in each bank
	logic bank_mem [`DN_BANKS][`DN_LUT_DEPTH];

	logic  bank_a;
	logic  bank_b;
	page_t page_a;
	page_t page_b;
	row_t  row_a;
	row_t  row_b;
	row_t  row_wr;

	//////////////////////////////
	// Read address mapping
	//////////////////////////////

	// Port A
	assign bank_a = msg_a.y1_fold[0];
	assign page_a = {msg_a.mag, msg_a.y1_fold[`DN_MSG_W-1:1]};
	assign row_a  = {msg_a.offset, page_a};

	// Port B
	assign bank_b = msg_b.y1_fold[0];
	assign page_b = {msg_b.mag, msg_b.y1_fold[`DN_MSG_W-1:1]};
	assign row_b  = {msg_b.offset, page_b};

	//////////////////////////////
	// Table write
	//////////////////////////////

	assign row_wr = {write_addr_offset, page_write_addr};

	// Whole row at once, both banks share the index
	always_ff @(posedge read_clk) begin
		if (we) begin
			bank_mem[0][row_wr] <= lut_in_bank0;
			bank_mem[1][row_wr] <= lut_in_bank1;
		end
	end

	//////////////////////////////
	// Stage 1 read registers
	//////////////////////////////

	// Combinational read from the stage 0 address,
	// so a write lands in time for the next load here
	always_ff @(posedge read_clk or negedge arst_n) begin
		if (!arst_n) begin
			lut_a <= 1'b0;
			lut_b <= 1'b0;
		end else begin
			lut_a <= bank_mem[bank_a][row_a];
			lut_b <= bank_mem[bank_b][row_b];
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// An unknown enable would leave the row contents undefined for later reads
	we_known_a: assert property (
		@(posedge read_clk) disable iff (!arst_n)
		!$isunknown(we)
	) else $error("dn_lut_bank: write enable is unknown");

endmodule

//--- logic/dn_hard_decision.sv
`timescale 1ns/1ps

module dn_hard_decision (
	input  logic  read_clk,
	input  logic  arst_n,
	dn_msg_if.dst msg_a,
	dn_msg_if.dst msg_b,
	input  logic  lut_a,
	input  logic  lut_b,
	output logic  t_c_a,
	output logic  t_c_b
);

	// Flags held back one cycle to meet the table bit
	logic flag_d_a;
	logic flag_d_b;

	//////////////////////////////
	// Flag alignment
	//////////////////////////////

	always_ff @(posedge read_clk or negedge arst_n) begin
		if (!arst_n) begin
			flag_d_a <= 1'b0;
			flag_d_b <= 1'b0;
		end else begin
			flag_d_a <= msg_a.flag;
			flag_d_b <= msg_b.flag;
		end
	end

	//////////////////////////////
	// Stage 2 decision
	//////////////////////////////

	// Undo the fold on the stored decision
	always_ff @(posedge read_clk or negedge arst_n) begin
		if (!arst_n) begin
			t_c_a <= 1'b0;
			t_c_b <= 1'b0;
		end else begin
			t_c_a <= lut_a ^ flag_d_a;
			t_c_b <= lut_b ^ flag_d_b;
		end
	end

	// Every stage upstream starts cleared, so the first output after release stays low
	t_c_clear_a: assert property (
		@(posedge read_clk)
		$rose(arst_n) |=> (t_c_a == 1'b0) && (t_c_b == 1'b0)
	) else $error("dn_hard_decision: t_c not clear after reset release");

endmodule

//--- logic/dn_lut_out.sv
`timescale 1ns/1ps

module dn_lut_out (
	input  logic          read_clk,
	input  logic          arst_n,

	// Read port A
	input  logic          transpose_en_a,
	input  dn_pkg::msg_t  y0_a,
	input  dn_pkg::msg_t  y1_a,

	// Read port B
	input  logic          transpose_en_b,
	input  dn_pkg::msg_t  y0_b,
	input  dn_pkg::msg_t  y1_b,

	// Shared page offset for both read ports
	input  logic          read_addr_offset,

	// Write port
	input  logic          lut_in_bank0,
	input  logic          lut_in_bank1,
	input  dn_pkg::page_t page_write_addr,
	input  logic          write_addr_offset,
	input  logic          we,

	// Hard decisions
	output logic          t_c_a,
	output logic          t_c_b
);

	// Folded messages, one bundle per port
	dn_msg_if msg_a_if ();
	dn_msg_if msg_b_if ();

	// Stage 1 table bits
	logic lut_a;
	logic lut_b;

	//////////////////////////////
	// Stage 0
	//////////////////////////////

	dn_msg_fold fold_a_i (
		.read_clk         (read_clk),
		.arst_n           (arst_n),
		.transpose_en     (transpose_en_a),
		.y0               (y0_a),
		.y1               (y1_a),
		.read_addr_offset (read_addr_offset),
		.msg              (msg_a_if.src)
	);

	dn_msg_fold fold_b_i (
		.read_clk         (read_clk),
		.arst_n           (arst_n),
		.transpose_en     (transpose_en_b),
		.y0               (y0_b),
		.y1               (y1_b),
		.read_addr_offset (read_addr_offset),
		.msg              (msg_b_if.src)
	);

	//////////////////////////////
	// Stage 1
	//////////////////////////////

	dn_lut_bank lut_i (
		.read_clk          (read_clk),
		.arst_n            (arst_n),
		.msg_a             (msg_a_if.dst),
		.msg_b             (msg_b_if.dst),
		.we                (we),
		.lut_in_bank0      (lut_in_bank0),
		.lut_in_bank1      (lut_in_bank1),
		.page_write_addr   (page_write_addr),
		.write_addr_offset (write_addr_offset),
		.lut_a             (lut_a),
		.lut_b             (lut_b)
	);

	//////////////////////////////
	// Stage 2
	//////////////////////////////

	dn_hard_decision hd_i (
		.read_clk (read_clk),
		.arst_n   (arst_n),
		.msg_a    (msg_a_if.dst),
		.msg_b    (msg_b_if.dst),
		.lut_a    (lut_a),
		.lut_b    (lut_b),
		.t_c_a    (t_c_a),
		.t_c_b    (t_c_b)
	);

endmodule

//--- tests/dn_lut_out_tb.sv
`timescale 1ns/1ps
`include "dn_defines.svh"

module dn_lut_out_tb;
	import dn_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 4;
	localparam int LAT = `DN_LATENCY;
	localparam int FILL_CYCLES = `DN_LUT_DEPTH + 1;
	localparam int READBACK_CYCLES = 2 * 256;
	localparam int FOLD_CYCLES = 4 * 16;
	localparam int INDEP_CYCLES = 64;
	localparam int REWRITE_CYCLES = 3 * 32;
	localparam int LOOKUP_CYCLES = READBACK_CYCLES + FOLD_CYCLES + INDEP_CYCLES + REWRITE_CYCLES;
	localparam int TOTAL_CYCLES = RESET_CYCLES + FILL_CYCLES + LOOKUP_CYCLES + LAT + 4;

	// Test tags carried along the expectation pipe
	localparam int T_RESET = 0;
	localparam int T_READBACK = 1;
	localparam int T_FOLD = 2;
	localparam int T_INDEP = 3;
	localparam int T_REWRITE = 4;

	logic  read_clk;
	logic  arst_n;
	logic  transpose_en_a;
	msg_t  y0_a;
	msg_t  y1_a;
	logic  transpose_en_b;
	msg_t  y0_b;
	msg_t  y1_b;
	logic  read_addr_offset;
	logic  lut_in_bank0;
	logic  lut_in_bank1;
	page_t page_write_addr;
	logic  write_addr_offset;
	logic  we;
	logic  t_c_a;
	logic  t_c_b;

	// Shadow table and expectation pipe
	logic           shadow [`DN_BANKS][`DN_LUT_DEPTH];
	logic           chk_en;
	int             test_id;
	logic [LAT-1:0] vld_q = '0;
	logic [LAT-1:0] exp_a_q = '0;
	logic [LAT-1:0] exp_b_q = '0;
	int             tid_q [LAT];
	int             err_a = 0;
	int             err_b = 0;
	int             other_err = 0;
	int             lookups = 0;

	dn_lut_out dut_i (.*);

	initial begin
		read_clk = 1'b0;
		forever #(CLK_PERIOD / 2) read_clk = ~read_clk;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic string test_name(input int id);
		case (id)
			T_RESET:    return "reset_state";
			T_READBACK: return "full_readback";
			T_FOLD:     return "fold_symmetry";
			T_INDEP:    return "port_independence";
			default:    return "write_then_read";
		endcase
	endfunction

	// Expected t_c from the fold, address and decision rules
	function automatic logic expect_decision(input logic te, input msg_t y0, input msg_t y1,
			input logic off);
		logic s;
		logic flag;
		mag_t mag;
		msg_t yf;
		row_t row;
		s = y0[`DN_MSG_W-1];
		mag = s ? ~y0[2:0] : y0[2:0];
		flag = te ^ s;
		yf = flag ? ~y1 : y1;
		row = {off, mag, yf[3:1]};
		return shadow[yf[0]][row] ^ flag;
	endfunction

	// Writes sampled at an edge are visible to reads sampled at the same edge
	always @(posedge read_clk) begin
		row_t wr_row;
		logic ea;
		logic eb;
		if (we) begin
			wr_row = {write_addr_offset, page_write_addr};
			shadow[0][wr_row] = lut_in_bank0;
			shadow[1][wr_row] = lut_in_bank1;
		end
		ea = 1'b0;
		eb = 1'b0;
		if (arst_n && chk_en) begin
			ea = expect_decision(transpose_en_a, y0_a, y1_a, read_addr_offset);
			eb = expect_decision(transpose_en_b, y0_b, y1_b, read_addr_offset);
			lookups++;
		end
		// While in reset the pipeline only carries zeros
		vld_q <= {vld_q[LAT-2:0], !arst_n || chk_en};
		exp_a_q <= {exp_a_q[LAT-2:0], ea};
		exp_b_q <= {exp_b_q[LAT-2:0], eb};
		tid_q[0] <= arst_n ? test_id : T_RESET;
		for (int i = 1; i < LAT; i++) begin
			tid_q[i] <= tid_q[i-1];
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	t_c_a_chk: assert property (@(negedge read_clk)
		vld_q[LAT-1] |-> t_c_a === exp_a_q[LAT-1])
	else begin
		err_a++;
		$display("ERR %s port A expected %0b actual %0b",
			test_name(tid_q[LAT-1]), exp_a_q[LAT-1], t_c_a);
	end

	t_c_b_chk: assert property (@(negedge read_clk)
		vld_q[LAT-1] |-> t_c_b === exp_b_q[LAT-1])
	else begin
		err_b++;
		$display("ERR %s port B expected %0b actual %0b",
			test_name(tid_q[LAT-1]), exp_b_q[LAT-1], t_c_b);
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	// Message pair that lands on a given bank and row
	function automatic void aim(input row_t row, input logic bank, input logic te,
			input logic s, output msg_t y0, output msg_t y1);
		logic flag;
		mag_t mag;
		msg_t yf;
		flag = te ^ s;
		mag = row[5:3];
		yf = {row[2:0], bank};
		y0 = {s, s ? ~mag : mag};
		y1 = flag ? ~yf : yf;
	endfunction

	task automatic tag(input int id);
		chk_en <= 1'b1;
		test_id <= id;
	endtask

	task automatic drive_reads(input logic te_a, input msg_t ya0, input msg_t ya1,
			input logic te_b, input msg_t yb0, input msg_t yb1);
		transpose_en_a <= te_a;
		y0_a <= ya0;
		y1_a <= ya1;
		transpose_en_b <= te_b;
		y0_b <= yb0;
		y1_b <= yb1;
	endtask

	task automatic write_row(input row_t row, input logic b0, input logic b1);
		we <= 1'b1;
		write_addr_offset <= row[`DN_PAGE_W];
		page_write_addr <= row[`DN_PAGE_W-1:0];
		lut_in_bank0 <= b0;
		lut_in_bank1 <= b1;
	endtask

	task automatic fill_table();
		logic [31:0] r;
		for (int i = 0; i < `DN_LUT_DEPTH; i++) begin
			@(posedge read_clk);
			r = $urandom();
			write_row(row_t'(i), r[0], r[1]);
		end
		@(posedge read_clk);
		we <= 1'b0;
	endtask

	// Every y0/y1 pair on both offsets with port B in another order
	task automatic sweep_readback();
		logic [31:0] r;
		logic [7:0] idx;
		for (int off = 0; off < 2; off++) begin
			for (int i = 0; i < 256; i++) begin
				@(posedge read_clk);
				r = $urandom();
				idx = 8'(i);
				tag(T_READBACK);
				read_addr_offset <= off[0];
				drive_reads(r[0], idx[7:4], idx[3:0], r[1], ~idx[3:0], idx[7:4]);
			end
		end
	endtask

	// Four sign and transpose combinations folding onto one entry
	task automatic sweep_fold();
		logic [31:0] r;
		msg_t ya0;
		msg_t ya1;
		msg_t yb0;
		msg_t yb1;
		for (int p = 0; p < 16; p++) begin
			r = $urandom();
			for (int k = 0; k < 4; k++) begin
				@(posedge read_clk);
				tag(T_FOLD);
				aim(r[6:0], r[7], k[0], k[1], ya0, ya1);
				aim(r[6:0], ~r[7], ~k[0], k[1], yb0, yb1);
				read_addr_offset <= r[6];
				drive_reads(k[0], ya0, ya1, ~k[0], yb0, yb1);
			end
		end
	endtask

	task automatic read_distinct_rows();
		logic [31:0] r;
		row_t row_a;
		row_t row_b;
		page_t mask;
		msg_t ya0;
		msg_t ya1;
		msg_t yb0;
		msg_t yb1;
		for (int n = 0; n < INDEP_CYCLES; n++) begin
			@(posedge read_clk);
			tag(T_INDEP);
			r = $urandom();
			row_a = r[6:0];
			mask = r[12:7];
			if (mask == '0) begin
				mask = 6'd1;
			end
			// Offset is shared, so the pages must differ
			row_b = {row_a[6], row_a[5:0] ^ mask};
			aim(row_a, r[13], r[14], r[15], ya0, ya1);
			aim(row_b, ~r[13], r[16], r[17], yb0, yb1);
			read_addr_offset <= row_a[6];
			drive_reads(r[14], ya0, ya1, r[16], yb0, yb1);
		end
	endtask

	task automatic rewrite_rows();
		logic [31:0] r;
		row_t row;
		msg_t ya0;
		msg_t ya1;
		msg_t yb0;
		msg_t yb1;
		for (int n = 0; n < REWRITE_CYCLES / 3; n++) begin
			r = $urandom();
			row = r[6:0];
			for (int c = 0; c < 3; c++) begin
				@(posedge read_clk);
				tag(T_REWRITE);
				aim(row, 1'b0, r[7], r[8], ya0, ya1);
				aim(row, 1'b1, r[9], r[10], yb0, yb1);
				read_addr_offset <= row[6];
				drive_reads(r[7], ya0, ya1, r[9], yb0, yb1);
				// Middle cycle flips both banks of the row under read
				if (c == 1) begin
					write_row(row, ~shadow[0][row], ~shadow[1][row]);
				end else begin
					we <= 1'b0;
				end
			end
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		void'($urandom(53));
		arst_n <= 1'b0;
		chk_en <= 1'b0;
		test_id <= T_RESET;
		read_addr_offset <= 1'b0;
		drive_reads(1'b0, '0, '0, 1'b0, '0, '0);
		we <= 1'b0;
		lut_in_bank0 <= 1'b0;
		lut_in_bank1 <= 1'b0;
		page_write_addr <= '0;
		write_addr_offset <= 1'b0;
		repeat (RESET_CYCLES) @(posedge read_clk);
		arst_n <= 1'b1;
		fill_table();
		sweep_readback();
		sweep_fold();
		read_distinct_rows();
		rewrite_rows();
		@(posedge read_clk);
		chk_en <= 1'b0;
		we <= 1'b0;
		// Drain the lookups still in flight
		repeat (LAT + 2) @(posedge read_clk);
		if (lookups != LOOKUP_CYCLES) begin
			$display("Stimulus issued %0d lookups instead of %0d", lookups, LOOKUP_CYCLES);
			other_err++;
		end
		$display("Errors: port A %0d, port B %0d, other %0d, lookups %0d",
			err_a, err_b, other_err, lookups);
		if (err_a + err_b + other_err == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD * 3 / 2);
		$display("Watchdog expired after %0d ns, stimulus did not complete",
			TOTAL_CYCLES * CLK_PERIOD * 3 / 2);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- list.f
+incdir+include
logic/dn_pkg.sv
logic/dn_msg_if.sv
logic/dn_msg_fold.sv
logic/dn_lut_bank.sv
logic/dn_hard_decision.sv
logic/dn_lut_out.sv
tests/dn_lut_out_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dn_lut_out testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module dn_lut_out_tb -o dn_lut_out_sim

./obj_dir/dn_lut_out_sim | tee sim.log

if grep -qx "TEST OK" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
